//--- common/rv_pkg.sv
// ----------------------------------------------------------------------
// RV32I pipeline shared definitions
// ----------------------------------------------------------------------
`default_nettype none

package rv_pkg;

    // Widths that carry a meaning
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_index_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // Major opcodes of the supported RV32I subset
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;

    // ADDI x0, x0, 0
    localparam word_t NOP_INSTRUCTION = 32'h0000_0013;

    // ------------------------------------------------------------------
    // Stage bundles
    // ------------------------------------------------------------------
    typedef struct packed {
        word_t      pc;
        word_t      next_pc;
        opcode_t    opcode;
        funct3_t    funct3;
        funct7_t    funct7;
        word_t      immediate;
        word_t      rs1_value;
        word_t      rs2_value;
        reg_index_t write_index;
        logic       write_enable;
    } de_ex_t;

    typedef struct packed {
        opcode_t    opcode;
        reg_index_t write_index;
        logic       write_enable;
        word_t      result;
        word_t      address;
        word_t      store_data;
    } ex_mw_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

    // Register write, also used as a forwarding source
    typedef struct packed {
        logic       enable;
        reg_index_t index;
        word_t      data;
    } reg_write_t;

endpackage

`default_nettype wire

//--- fetch/fetch_stage.sv
// ----------------------------------------------------------------------
// Fetch stage
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module fetch_stage #(
    parameter rv_pkg::word_t RESET_ADDRESS = 32'h0000_0000
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              stall,
    input  rv_pkg::redirect_t redirect,
    output logic              imem_enable,
    output rv_pkg::word_t     imem_address,
    input  rv_pkg::word_t     imem_data,
    output rv_pkg::word_t     instruction,
    output rv_pkg::word_t     pc,
    output rv_pkg::word_t     next_pc
);

    logic          running;
    rv_pkg::word_t fetch_pc;
    rv_pkg::word_t fetch_next_pc;
    logic          advance;

    assign fetch_next_pc = fetch_pc + 32'd4;
    assign advance       = running && !stall;
    assign imem_enable   = running;
    assign imem_address  = fetch_pc;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            running     <= 1'b0;
            fetch_pc    <= RESET_ADDRESS;
            instruction <= rv_pkg::NOP_INSTRUCTION;
        end
        else
        begin
            running <= 1'b1;
            // A taken jump flushes the word fetched this cycle
            if (redirect.taken)
            begin
                fetch_pc    <= redirect.target;
                instruction <= rv_pkg::NOP_INSTRUCTION;
            end
            else if (advance)
            begin
                fetch_pc    <= fetch_next_pc;
                instruction <= imem_data;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (advance)
        begin
            pc      <= fetch_pc;
            next_pc <= fetch_next_pc;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        redirect.taken |-> redirect.target[1:0] == 2'b00)
        else $error("Misaligned jump target %h", redirect.target);

endmodule

`default_nettype wire

//--- decode/register_file.sv
// ----------------------------------------------------------------------
// Integer register file
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module register_file #(
    parameter int REG_COUNT = 32
) (
    input  logic               clk,
    input  logic               reset,
    input  rv_pkg::reg_index_t read_index_1,
    input  rv_pkg::reg_index_t read_index_2,
    output rv_pkg::word_t      read_data_1,
    output rv_pkg::word_t      read_data_2,
    input  rv_pkg::reg_write_t write
);

    localparam int INDEX_BITS = $clog2(REG_COUNT);

    rv_pkg::word_t registers [REG_COUNT];

    // Register zero reads zero, a same-cycle write passes straight through
    function automatic rv_pkg::word_t read_port(rv_pkg::reg_index_t index);
        if (index == '0)
            return '0;
        if (write.enable && write.index == index)
            return write.data;
        return registers[index[INDEX_BITS-1:0]];
    endfunction

    always_comb
    begin
        read_data_1 = read_port(read_index_1);
        read_data_2 = read_port(read_index_2);
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < REG_COUNT; i++)
                registers[i] <= '0;
        end
        else if (write.enable && write.index != '0)
            registers[write.index[INDEX_BITS-1:0]] <= write.data;
    end

    assert property (@(posedge clk) disable iff (reset)
        write.enable |-> int'(write.index) < REG_COUNT)
        else $error("Write to missing register x%0d", write.index);

endmodule

`default_nettype wire

//--- decode/decode_stage.sv
// ----------------------------------------------------------------------
// Decode stage with forwarding and load-use stall
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module decode_stage #(
    parameter int REG_COUNT = 32
) (
    input  logic               clk,
    input  logic               reset,
    input  rv_pkg::word_t      instruction,
    input  rv_pkg::word_t      pc,
    input  rv_pkg::word_t      next_pc,
    input  rv_pkg::redirect_t  redirect,
    input  rv_pkg::reg_write_t ex_forward,
    input  rv_pkg::reg_write_t mw_write,
    output logic               stall,
    output rv_pkg::de_ex_t     de_ex
);

    rv_pkg::opcode_t    opcode;
    rv_pkg::reg_index_t rs1_index;
    rv_pkg::reg_index_t rs2_index;
    rv_pkg::reg_index_t rd_index;
    rv_pkg::word_t      rf_data_1;
    rv_pkg::word_t      rf_data_2;
    logic               uses_rs1;
    logic               uses_rs2;
    logic               writes_rd;
    rv_pkg::de_ex_t     decoded;

    assign opcode    = instruction[6:0];
    assign rs1_index = instruction[19:15];
    assign rs2_index = instruction[24:20];
    assign rd_index  = instruction[11:7];

    assign uses_rs1 = opcode inside {rv_pkg::OPC_OP, rv_pkg::OPC_OP_IMM, rv_pkg::OPC_JALR,
                                     rv_pkg::OPC_BRANCH, rv_pkg::OPC_LOAD, rv_pkg::OPC_STORE};
    assign uses_rs2 = opcode inside {rv_pkg::OPC_OP, rv_pkg::OPC_BRANCH, rv_pkg::OPC_STORE};
    assign writes_rd = opcode inside {rv_pkg::OPC_OP, rv_pkg::OPC_OP_IMM, rv_pkg::OPC_LUI,
                                      rv_pkg::OPC_AUIPC, rv_pkg::OPC_JAL, rv_pkg::OPC_JALR,
                                      rv_pkg::OPC_LOAD};

    register_file #(
        .REG_COUNT (REG_COUNT)
    ) i_register_file (
        .clk          (clk),
        .reset        (reset),
        .read_index_1 (rs1_index),
        .read_index_2 (rs2_index),
        .read_data_1  (rf_data_1),
        .read_data_2  (rf_data_2),
        .write        (mw_write)
    );

    // Execute result wins over memory/write-back
    function automatic rv_pkg::word_t forward(rv_pkg::reg_index_t index,
                                              rv_pkg::word_t rf_value);
        if (index != '0 && ex_forward.enable && ex_forward.index == index)
            return ex_forward.data;
        if (index != '0 && mw_write.enable && mw_write.index == index)
            return mw_write.data;
        return rf_value;
    endfunction

    always_comb
    begin
        decoded.pc           = pc;
        decoded.next_pc      = next_pc;
        decoded.opcode       = opcode;
        decoded.funct3       = instruction[14:12];
        decoded.funct7       = instruction[31:25];
        decoded.rs1_value    = forward(rs1_index, rf_data_1);
        decoded.rs2_value    = forward(rs2_index, rf_data_2);
        decoded.write_index  = rd_index;
        decoded.write_enable = writes_rd && rd_index != '0;
        case (opcode)
            rv_pkg::OPC_OP_IMM, rv_pkg::OPC_JALR, rv_pkg::OPC_LOAD:
                decoded.immediate = {{20{instruction[31]}}, instruction[31:20]};
            rv_pkg::OPC_STORE:
                decoded.immediate = {{20{instruction[31]}}, instruction[31:25],
                                     instruction[11:7]};
            rv_pkg::OPC_BRANCH:
                decoded.immediate = {{19{instruction[31]}}, instruction[31], instruction[7],
                                     instruction[30:25], instruction[11:8], 1'b0};
            rv_pkg::OPC_LUI, rv_pkg::OPC_AUIPC:
                decoded.immediate = {instruction[31:12], 12'b0};
            rv_pkg::OPC_JAL:
                decoded.immediate = {{11{instruction[31]}}, instruction[31],
                                     instruction[19:12], instruction[20],
                                     instruction[30:21], 1'b0};
            default:
                decoded.immediate = '0;
        endcase
    end

    // Load data is not ready until memory/write-back
    assign stall = de_ex.opcode == rv_pkg::OPC_LOAD && de_ex.write_enable &&
                   ((uses_rs1 && de_ex.write_index == rs1_index) ||
                    (uses_rs2 && de_ex.write_index == rs2_index));

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            de_ex        <= '0;
            de_ex.opcode <= rv_pkg::OPC_OP_IMM;
        end
        else if (redirect.taken || stall)
        begin
            de_ex        <= '0;
            de_ex.opcode <= rv_pkg::OPC_OP_IMM;
        end
        else
            de_ex <= decoded;
    end

endmodule

`default_nettype wire

//--- execute/execute_stage.sv
// ----------------------------------------------------------------------
// Execute stage
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
    input  logic               clk,
    input  logic               reset,
    input  rv_pkg::de_ex_t     de_ex,
    output rv_pkg::redirect_t  redirect,
    output rv_pkg::reg_write_t ex_forward,
    output rv_pkg::ex_mw_t     ex_mw
);

    rv_pkg::word_t operand_a;
    rv_pkg::word_t operand_b;
    logic [4:0]    shift_amount;
    logic          subtract;
    rv_pkg::word_t alu_result;
    logic          condition_true;
    rv_pkg::word_t address_base;
    rv_pkg::word_t address_sum;
    rv_pkg::word_t address;
    rv_pkg::word_t result;

    // ------------------------------------------------------------------
    // ALU
    // ------------------------------------------------------------------
    assign operand_a    = de_ex.rs1_value;
    assign operand_b    = de_ex.opcode == rv_pkg::OPC_OP ? de_ex.rs2_value : de_ex.immediate;
    assign shift_amount = operand_b[4:0];
    assign subtract     = de_ex.opcode == rv_pkg::OPC_OP && de_ex.funct7[5];

    always_comb
    begin
        case (de_ex.funct3)
            3'b000: alu_result = subtract ? operand_a - operand_b : operand_a + operand_b;
            3'b001: alu_result = operand_a << shift_amount;
            3'b010: alu_result = {31'b0, $signed(operand_a) < $signed(operand_b)};
            3'b011: alu_result = {31'b0, operand_a < operand_b};
            3'b100: alu_result = operand_a ^ operand_b;
            3'b101:
            begin
                // SRA and SRAI both carry funct7 bit 5
                if (de_ex.funct7[5])
                    alu_result = rv_pkg::word_t'($signed(operand_a) >>> shift_amount);
                else
                    alu_result = operand_a >> shift_amount;
            end
            3'b110: alu_result = operand_a | operand_b;
            default: alu_result = operand_a & operand_b;
        endcase
    end

    // ------------------------------------------------------------------
    // Branch decision and address generation
    // ------------------------------------------------------------------
    always_comb
    begin
        case (de_ex.funct3)
            3'b000: condition_true = de_ex.rs1_value == de_ex.rs2_value;
            3'b001: condition_true = de_ex.rs1_value != de_ex.rs2_value;
            3'b100: condition_true = $signed(de_ex.rs1_value) < $signed(de_ex.rs2_value);
            3'b101: condition_true = $signed(de_ex.rs1_value) >= $signed(de_ex.rs2_value);
            3'b110: condition_true = de_ex.rs1_value < de_ex.rs2_value;
            3'b111: condition_true = de_ex.rs1_value >= de_ex.rs2_value;
            default: condition_true = 1'b0;
        endcase
    end

    assign address_base = de_ex.opcode inside {rv_pkg::OPC_JALR, rv_pkg::OPC_LOAD,
                                               rv_pkg::OPC_STORE} ? de_ex.rs1_value : de_ex.pc;
    assign address_sum  = address_base + de_ex.immediate;
    assign address      = de_ex.opcode == rv_pkg::OPC_JALR ? {address_sum[31:1], 1'b0}
                                                           : address_sum;

    assign redirect.taken  = de_ex.opcode == rv_pkg::OPC_JAL ||
                             de_ex.opcode == rv_pkg::OPC_JALR ||
                             (de_ex.opcode == rv_pkg::OPC_BRANCH && condition_true);
    assign redirect.target = address;

    // One result per instruction, shared by forwarding and the memory stage
    always_comb
    begin
        case (de_ex.opcode)
            rv_pkg::OPC_LUI:                  result = de_ex.immediate;
            rv_pkg::OPC_AUIPC:                result = address;
            rv_pkg::OPC_JAL, rv_pkg::OPC_JALR: result = de_ex.next_pc;
            default:                          result = alu_result;
        endcase
    end

    // A load only has its address here
    assign ex_forward.enable = de_ex.write_enable && de_ex.opcode != rv_pkg::OPC_LOAD;
    assign ex_forward.index  = de_ex.write_index;
    assign ex_forward.data   = result;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            ex_mw        <= '0;
            ex_mw.opcode <= rv_pkg::OPC_OP_IMM;
        end
        else
        begin
            ex_mw.opcode       <= de_ex.opcode;
            ex_mw.write_index  <= de_ex.write_index;
            ex_mw.write_enable <= de_ex.write_enable;
            ex_mw.result       <= result;
            ex_mw.address      <= address;
            ex_mw.store_data   <= de_ex.rs2_value;
        end
    end

endmodule

`default_nettype wire

//--- rtl/memory_writeback.sv
// ----------------------------------------------------------------------
// Memory access and write-back
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module memory_writeback (
    input  rv_pkg::ex_mw_t     ex_mw,
    output logic               dmem_enable,
    output logic               dmem_write,
    output rv_pkg::word_t      dmem_address,
    output rv_pkg::word_t      dmem_write_data,
    input  rv_pkg::word_t      dmem_read_data,
    output rv_pkg::reg_write_t mw_write
);

    logic is_load;
    logic is_store;
    logic no_writeback;

    assign is_load      = ex_mw.opcode == rv_pkg::OPC_LOAD;
    assign is_store     = ex_mw.opcode == rv_pkg::OPC_STORE;
    assign no_writeback = is_store || ex_mw.opcode == rv_pkg::OPC_BRANCH;

    // Word accesses only
    assign dmem_enable     = is_load || is_store;
    assign dmem_write      = is_store;
    assign dmem_address    = ex_mw.address;
    assign dmem_write_data = ex_mw.store_data;

    // Register write and second forwarding source
    assign mw_write.enable = ex_mw.write_enable && !no_writeback;
    assign mw_write.index  = ex_mw.write_index;
    assign mw_write.data   = is_load ? dmem_read_data : ex_mw.result;

endmodule

`default_nettype wire

//--- rtl/rv_core.sv
// ----------------------------------------------------------------------
// Four-stage RV32I core
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module rv_core #(
    parameter rv_pkg::word_t RESET_ADDRESS = 32'h0000_0000,
    parameter int            REG_COUNT     = 32
) (
    input  logic          clk,
    input  logic          reset,
    output logic          imem_enable,
    output rv_pkg::word_t imem_address,
    input  rv_pkg::word_t imem_data,
    output logic          dmem_enable,
    output logic          dmem_write,
    output rv_pkg::word_t dmem_address,
    output rv_pkg::word_t dmem_write_data,
    input  rv_pkg::word_t dmem_read_data
);

    logic               stall;
    rv_pkg::redirect_t  redirect;
    rv_pkg::word_t      instruction;
    rv_pkg::word_t      pc;
    rv_pkg::word_t      next_pc;
    rv_pkg::de_ex_t     de_ex;
    rv_pkg::ex_mw_t     ex_mw;
    rv_pkg::reg_write_t ex_forward;
    rv_pkg::reg_write_t mw_write;

    fetch_stage #(
        .RESET_ADDRESS (RESET_ADDRESS)
    ) i_fetch (
        .clk          (clk),
        .reset        (reset),
        .stall        (stall),
        .redirect     (redirect),
        .imem_enable  (imem_enable),
        .imem_address (imem_address),
        .imem_data    (imem_data),
        .instruction  (instruction),
        .pc           (pc),
        .next_pc      (next_pc)
    );

    decode_stage #(
        .REG_COUNT (REG_COUNT)
    ) i_decode (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .pc          (pc),
        .next_pc     (next_pc),
        .redirect    (redirect),
        .ex_forward  (ex_forward),
        .mw_write    (mw_write),
        .stall       (stall),
        .de_ex       (de_ex)
    );

    execute_stage i_execute (
        .clk        (clk),
        .reset      (reset),
        .de_ex      (de_ex),
        .redirect   (redirect),
        .ex_forward (ex_forward),
        .ex_mw      (ex_mw)
    );

    memory_writeback i_memory_writeback (
        .ex_mw           (ex_mw),
        .dmem_enable     (dmem_enable),
        .dmem_write      (dmem_write),
        .dmem_address    (dmem_address),
        .dmem_write_data (dmem_write_data),
        .dmem_read_data  (dmem_read_data),
        .mw_write        (mw_write)
    );

endmodule

`default_nettype wire

//--- testbench/tb_memory.sv
// ----------------------------------------------------------------------
// Instruction and data memory models
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_memory #(
    parameter int IMEM_WORDS = 64,
    parameter int DMEM_WORDS = 512
) (
    input  logic          clk,
    input  logic          imem_enable,
    input  rv_pkg::word_t imem_address,
    output rv_pkg::word_t imem_data,
    input  logic          dmem_enable,
    input  logic          dmem_write,
    input  rv_pkg::word_t dmem_address,
    input  rv_pkg::word_t dmem_write_data,
    output rv_pkg::word_t dmem_read_data
);

    localparam int IMEM_BITS = $clog2(IMEM_WORDS);
    localparam int DMEM_BITS = $clog2(DMEM_WORDS);

    rv_pkg::word_t instruction_words [IMEM_WORDS];
    rv_pkg::word_t data_words [DMEM_WORDS];
    logic          imem_in_range;
    logic          dmem_in_range;

    assign imem_in_range = imem_address[31:IMEM_BITS+2] == '0;
    assign dmem_in_range = dmem_address[31:DMEM_BITS+2] == '0;

    // Both memories answer in the same cycle
    assign imem_data = (imem_enable && imem_in_range)
                       ? instruction_words[imem_address[IMEM_BITS+1:2]]
                       : rv_pkg::NOP_INSTRUCTION;
    assign dmem_read_data = (dmem_enable && dmem_in_range)
                            ? data_words[dmem_address[DMEM_BITS+1:2]]
                            : '0;

    // Fill pattern that differs for every word address
    initial
    begin
        for (int i = 0; i < DMEM_WORDS; i++)
            data_words[i] = (rv_pkg::word_t'(i) * 32'h9E37_79B9) ^ 32'h5A5A_0000;
    end

    always @(posedge clk)
    begin
        if (dmem_enable && dmem_write && dmem_in_range)
            data_words[dmem_address[DMEM_BITS+1:2]] <= dmem_write_data;
    end

endmodule

`default_nettype wire

//--- testbench/tb_top.sv
// ----------------------------------------------------------------------
// RV32I pipeline testbench
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_top;

    localparam rv_pkg::word_t RESET_ADDRESS = 32'h0000_0000;
    localparam int REG_COUNT      = 32;
    localparam int PROGRAM_WORDS  = 64;
    localparam int EXPECT_BASE    = 64;
    localparam int TESTDATA_WORDS = 128;
    localparam int TEST_COUNT     = 6;
    localparam int CYCLE_LIMIT    = 4 * PROGRAM_WORDS + 100;
    localparam int DRAIN_CYCLES   = 20;

    logic          clk;
    logic          reset;
    logic          imem_enable;
    rv_pkg::word_t imem_address;
    rv_pkg::word_t imem_data;
    logic          dmem_enable;
    logic          dmem_write;
    rv_pkg::word_t dmem_address;
    rv_pkg::word_t dmem_write_data;
    rv_pkg::word_t dmem_read_data;

    rv_pkg::word_t testdata [TESTDATA_WORDS];
    int            expect_count;
    int            expect_index;
    int            error_count;
    int            test_errors;
    int            tests_passed;
    int            cycle_count;
    int            drain_count;
    logic          timed_out;
    logic          first_fetch_seen;

    rv_core #(
        .RESET_ADDRESS (RESET_ADDRESS),
        .REG_COUNT     (REG_COUNT)
    ) i_dut (
        .clk             (clk),
        .reset           (reset),
        .imem_enable     (imem_enable),
        .imem_address    (imem_address),
        .imem_data       (imem_data),
        .dmem_enable     (dmem_enable),
        .dmem_write      (dmem_write),
        .dmem_address    (dmem_address),
        .dmem_write_data (dmem_write_data),
        .dmem_read_data  (dmem_read_data)
    );

    tb_memory #(
        .IMEM_WORDS (PROGRAM_WORDS)
    ) i_memory (
        .clk             (clk),
        .imem_enable     (imem_enable),
        .imem_address    (imem_address),
        .imem_data       (imem_data),
        .dmem_enable     (dmem_enable),
        .dmem_write      (dmem_write),
        .dmem_address    (dmem_address),
        .dmem_write_data (dmem_write_data),
        .dmem_read_data  (dmem_read_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Compare one store against the next expected entry
    task automatic check_store();
        int            test_number;
        rv_pkg::word_t expected_address;
        rv_pkg::word_t expected_data;
        int            base;
        if (expect_index >= expect_count)
        begin
            $display("Unexpected store of %h to address %h after the last expected one",
                     dmem_write_data, dmem_address);
            error_count++;
            return;
        end
        base             = EXPECT_BASE + 1 + 3 * expect_index;
        test_number      = int'(testdata[base]);
        expected_address = testdata[base + 1];
        expected_data    = testdata[base + 2];
        if (dmem_address !== expected_address)
        begin
            $display("** Error at %0t: dmem_address is %h, expected %h",
                     $time, dmem_address, expected_address);
            test_errors++;
        end
        if (dmem_write_data !== expected_data)
        begin
            $display("** Error at %0t: dmem_write_data is %h, expected %h",
                     $time, dmem_write_data, expected_data);
            test_errors++;
        end
        expect_index++;
        // Last entry of this test number closes the test
        if (expect_index == expect_count ||
            int'(testdata[EXPECT_BASE + 1 + 3 * expect_index]) != test_number)
        begin
            if (test_errors == 0)
            begin
                $display("Test %0d passed", test_number);
                tests_passed++;
            end
            else
                $display("Test %0d failed with %0d errors", test_number, test_errors);
            error_count += test_errors;
            test_errors = 0;
        end
    endtask

    initial
    begin
        reset            = 1'b1;
        expect_index     = 0;
        error_count      = 0;
        test_errors      = 0;
        tests_passed     = 0;
        cycle_count      = 0;
        drain_count      = 0;
        timed_out        = 1'b0;
        first_fetch_seen = 1'b0;

        $readmemh("testbench/program_testdata.hex", testdata);
        for (int i = 0; i < PROGRAM_WORDS; i++)
            i_memory.instruction_words[i] = testdata[i];
        expect_count = int'(testdata[EXPECT_BASE]);

        // Fetch and data memory stay idle while reset is held
        @(negedge clk);
        if (imem_enable !== 1'b0)
        begin
            $display("** Error at %0t: imem_enable is %b, expected %b",
                     $time, imem_enable, 1'b0);
            error_count++;
        end
        if (dmem_enable !== 1'b0)
        begin
            $display("** Error at %0t: dmem_enable is %b, expected %b",
                     $time, dmem_enable, 1'b0);
            error_count++;
        end

        // Remaining reset cycles
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        // Sample on the falling edge where DUT outputs are settled
        while (drain_count < DRAIN_CYCLES && !timed_out)
        begin
            @(negedge clk);
            cycle_count++;
            if (imem_enable && !first_fetch_seen)
            begin
                first_fetch_seen = 1'b1;
                if (imem_address !== RESET_ADDRESS)
                begin
                    $display("** Error at %0t: imem_address is %h, expected %h",
                             $time, imem_address, RESET_ADDRESS);
                    error_count++;
                end
            end
            if (dmem_enable && dmem_write)
                check_store();
            if (expect_index >= expect_count)
                drain_count++;
            if (cycle_count >= CYCLE_LIMIT)
                timed_out = 1'b1;
        end

        if (timed_out)
        begin
            $display("Timeout after %0d cycles with %0d expected stores missing",
                     cycle_count, expect_count - expect_index);
            error_count++;
        end
        $display("Tests passed: %0d of %0d, errors: %0d", tests_passed, TEST_COUNT,
                 error_count);
        if (error_count == 0 && tests_passed == TEST_COUNT)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/program_testdata.hex
// Words 0x00-0x3F: program words at the reset address, in fetch order
// Word 0x40: expected store count, then lines of test number, address, value
@000
// Test 1: dependent ALU chain, register and immediate forms
00500093 00708113 002081B3 40118233 00321293 FFF2C313 40235393 0013A433
0013B4B3 10302023 10402223 10702423 10802623 10902823
// Test 2: load followed by a dependent add
10002503 001505B3 20B02023
// Test 3: six branch kinds, taken ones skip a store to 0x300
00108463 30102023 00109463 20102223 0013C463 30102023 0013D463 20202423
0070E463 30102023 0070F463 20702623
// Test 4: JAL and JALR with link values
00C0066F 30102023 30102023 40C02023 09400693 00068767 30102023 30102023
40E02223
// Test 5: LUI and AUIPC
123457B7 00001817 40F02423 41002623
// Test 6: write to x0, then store x0
06300013 40002823
// Final loop
0000006F
@040
0000000E
00000001 00000100 00000011
00000001 00000104 0000000C
00000001 00000108 FFFFFFE7
00000001 0000010C 00000001
00000001 00000110 00000000
00000002 00000200 00000016
00000003 00000204 00000005
00000003 00000208 0000000C
00000003 0000020C FFFFFFE7
00000004 00000400 00000078
00000004 00000404 0000008C
00000005 00000408 12345000
00000005 0000040C 0000109C
00000006 00000410 00000000

//--- tb.f
common/rv_pkg.sv
fetch/fetch_stage.sv
decode/register_file.sv
decode/decode_stage.sv
execute/execute_stage.sv
rtl/memory_writeback.sv
rtl/rv_core.sv
testbench/tb_memory.sv
testbench/tb_top.sv

//--- run.sh
#!/bin/sh
# Build with Verilator and run the testbench from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing -f tb.f --top-module tb_top -o tb_sim &&
obj_dir/tb_sim | tee /dev/stderr | grep -q "Simulation completed successfully" &&
echo "PASS" || { echo "FAIL"; exit 1; }
